// ==== obj_pkg.sv ====
package obj_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // OAM attributes, word 1 low half on top of word 0
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [3:0] palette;      // Attribute 2
        logic [1:0] prio;
        logic [9:0] name;
        logic [1:0] size;         // Attribute 1
        logic       vflip;
        logic       hflip;
        logic [2:0] rsvd;         // Affine parameter select, unused for regular sprites
        logic [8:0] x;
        logic [1:0] shape;        // Attribute 0
        logic       color_8bpp;
        logic       mosaic;
        logic [1:0] mode;
        logic       obj_disable;
        logic       affine;
        logic [7:0] y;
    } oam_attr_t;

    typedef struct packed {
        logic obj_enable;
        logic map_1d;
    } obj_config_t;

    typedef struct packed {
        logic       opaque;
        logic [1:0] prio;
        logic [7:0] color;        // Palette index, bank in the high nibble for 4bpp
    } obj_pixel_t;

    typedef struct packed {
        logic [7:0] column;       // Screen column
        logic [5:0] px;           // Sprite coordinates after flip
        logic [5:0] py;
        logic [3:0] width_tiles;
        logic [9:0] name;
        logic       color_8bpp;
        logic [3:0] palette;
        logic [1:0] prio;
    } pixel_job_t;

    // One VRAM halfword, four 4bpp pixels or two 8bpp pixels
    typedef union packed {
        logic [3:0][3:0] nibbles;
        logic [1:0][7:0] bytes;
    } vram_word_u;

    typedef struct packed {
        logic [6:0] width;
        logic [6:0] height;
    } obj_dim_t;

    // Shape 3 gives a zero size, which no line can hit
    function automatic obj_dim_t obj_size(input logic [1:0] shape, input logic [1:0] size);
        obj_dim_t dim;
        case ({shape, size})
            4'b00_00: dim = {7'd8, 7'd8};
            4'b00_01: dim = {7'd16, 7'd16};
            4'b00_10: dim = {7'd32, 7'd32};
            4'b00_11: dim = {7'd64, 7'd64};
            4'b01_00: dim = {7'd16, 7'd8};   // Wide
            4'b01_01: dim = {7'd32, 7'd8};
            4'b01_10: dim = {7'd32, 7'd16};
            4'b01_11: dim = {7'd64, 7'd32};
            4'b10_00: dim = {7'd8, 7'd16};   // Tall
            4'b10_01: dim = {7'd8, 7'd32};
            4'b10_10: dim = {7'd16, 7'd32};
            4'b10_11: dim = {7'd32, 7'd64};
            default:  dim = '0;
        endcase
        return dim;
    endfunction

endpackage

// ==== obj_control_regs.sv ====
`timescale 1ns/1ps

module obj_control_regs (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 reg_write,
    input  logic [15:0]          reg_wdata,
    input  logic                 line_start,
    output obj_pkg::obj_config_t cfg
);
    import obj_pkg::*;

    obj_config_t pending;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            pending <= '0;
            cfg     <= '0;
        end else begin
            if (reg_write) begin
                pending.obj_enable <= reg_wdata[12];   // DISPCNT obj enable
                pending.map_1d     <= reg_wdata[6];    // DISPCNT 1D tile mapping
            end
            if (line_start) begin
                cfg <= pending;                        // One setting per scanline
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // The scan never sees the live configuration move under it
    cfg_stable_in_line: assert property (
        @(posedge clock) disable iff (reset)
        (cfg != $past(cfg)) |-> $past(line_start)
    );

endmodule

// ==== obj_attr_fetch.sv ====
`timescale 1ns/1ps

module obj_attr_fetch #(
    parameter int NUM_OBJECTS = 128,
    parameter int LINE_WIDTH  = 240
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 line_start,
    input  logic [7:0]           line,
    input  obj_pkg::obj_config_t cfg,
    output logic [8:0]           oam_addr,
    input  logic [31:0]          oam_data,
    output obj_pkg::pixel_job_t  job,
    output logic                 job_valid,
    output logic                 line_done
);
    import obj_pkg::*;

    typedef enum logic [2:0] {IDLE, READ0, WAIT0, READ1, WAIT1, EMIT} state_t;

    state_t      state;
    logic [7:0]  obj_index, cur_line, obj_row, next_row;
    logic [31:0] word0;
    oam_attr_t   attr, next_attr;
    obj_dim_t    dim, next_dim;
    logic [6:0]  col_offset;
    logic [8:0]  screen_col;
    logic [5:0]  px, py;
    logic        visible, last_obj, last_col, drain;

    always_comb begin
        next_attr = {oam_data[15:0], word0};
        next_dim  = obj_size(next_attr.shape, next_attr.size);
        next_row  = cur_line - next_attr.y;
        visible   = cfg.obj_enable && !next_attr.obj_disable && !next_attr.affine &&
                    !next_attr.mode[1] && (next_row < {1'b0, next_dim.height});
    end

    assign oam_addr   = {obj_index, state == READ1};   // Word select in the LSB
    assign last_obj   = (obj_index == 8'(NUM_OBJECTS - 1));
    assign last_col   = (col_offset == dim.width - 7'd1);
    assign screen_col = attr.x + {2'b00, col_offset};    // Wraps at 512
    assign px = attr.hflip ? dim.width[5:0] - 6'd1 - col_offset[5:0] : col_offset[5:0];
    assign py = attr.vflip ? dim.height[5:0] - 6'd1 - obj_row[5:0] : obj_row[5:0];

    assign job = '{column:      screen_col[7:0],
                   px:          px,
                   py:          py,
                   width_tiles: dim.width[6:3],
                   name:        attr.name,
                   color_8bpp:  attr.color_8bpp,
                   palette:     attr.palette,
                   prio:        attr.prio};
    assign job_valid = (state == EMIT) && (screen_col < 9'(LINE_WIDTH)) && !line_start;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            obj_index  <= '0;
            cur_line   <= '0;
            col_offset <= '0;
            drain      <= 1'b0;
            line_done  <= 1'b0;
        end else if (line_start) begin
            state     <= READ0;                          // Also aborts a running scan
            obj_index <= '0;
            cur_line  <= line;
            drain     <= 1'b0;
            line_done <= 1'b0;
        end else begin
            line_done <= drain;                          // Last job has left the pipe
            drain     <= 1'b0;
            case (state)
                READ0: state <= WAIT0;
                WAIT0: state <= READ1;
                READ1: state <= WAIT1;
                WAIT1, EMIT: begin
                    if (state == WAIT1 && visible) begin
                        state      <= EMIT;
                        col_offset <= '0;
                    end else if (state == EMIT && !last_col) begin
                        col_offset <= col_offset + 7'd1;
                    end else if (last_obj) begin
                        state <= IDLE;
                        drain <= 1'b1;
                    end else begin
                        state     <= READ0;
                        obj_index <= obj_index + 8'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == WAIT0) word0 <= oam_data;
        if (state == WAIT1 && visible) begin
            attr    <= next_attr;
            dim     <= next_dim;
            obj_row <= next_row;
        end
    end

    job_in_sprite: assert property (
        @(posedge clock) disable iff (reset)
        job_valid |-> (col_offset < dim.width) && (obj_row < {1'b0, dim.height})
    );
    done_is_pulse: assert property (
        @(posedge clock) disable iff (reset) line_done |=> !line_done
    );

endmodule

// ==== obj_tile_address.sv ====
`timescale 1ns/1ps

module obj_tile_address (
    input  logic                 clock,
    input  logic                 reset,
    input  obj_pkg::pixel_job_t  job,
    input  logic                 job_valid,
    input  obj_pkg::obj_config_t cfg,
    output logic [14:0]          vram_addr,
    output obj_pkg::pixel_job_t  stage_job,
    output logic                 stage_valid
);
    import obj_pkg::*;

    logic [7:0]  tile_col, tile_row, width_ext, tile_offset;
    logic [10:0] tile_index;
    logic [5:0]  in_tile_byte;
    logic [15:0] byte_addr;

    always_comb begin
        tile_col  = {5'b0, job.px[5:3]};
        tile_row  = {5'b0, job.py[5:3]};
        width_ext = {4'b0, job.width_tiles};
        if (cfg.map_1d) begin
            tile_offset = (tile_row * width_ext + tile_col) << job.color_8bpp;
        end else begin
            tile_offset = (tile_row << 5) + (tile_col << job.color_8bpp);   // 32-tile rows
        end
        tile_index = {1'b0, job.name} + {3'b0, tile_offset};
        if (job.color_8bpp) begin
            in_tile_byte = {job.py[2:0], job.px[2:0]};         // 8 bytes per row
        end else begin
            in_tile_byte = {1'b0, job.py[2:0], job.px[2:1]};   // 4 bytes per row
        end
        byte_addr = {tile_index, 5'b0} + {10'b0, in_tile_byte};
    end

    assign vram_addr = byte_addr[15:1];   // Halfword address, wraps at 32K

    ////////////////////////////////////////////////////////////////////////////
    // Stage register, lines up with the VRAM read data
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= job_valid;
        end
    end

    always_ff @(posedge clock) begin
        stage_job <= job;
    end

endmodule

// ==== obj_line_buffer.sv ====
`timescale 1ns/1ps

module obj_line_buffer #(
    parameter int LINE_WIDTH = 240
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                line_start,
    input  obj_pkg::pixel_job_t stage_job,
    input  logic                stage_valid,
    input  obj_pkg::vram_word_u vram_data,
    input  logic [7:0]          hcount,
    output obj_pkg::obj_pixel_t pixel
);
    import obj_pkg::*;

    logic                  back_sel;                     // Half being rendered
    logic [LINE_WIDTH-1:0] opaque_mem [2];
    logic [9:0]            data_mem   [2][LINE_WIDTH];   // Priority and colour
    logic [7:0]            pix_value, color;
    logic                  write_en;

    always_comb begin
        if (stage_job.color_8bpp) begin
            pix_value = vram_data.bytes[stage_job.px[0]];
            color     = pix_value;
        end else begin
            pix_value = {4'h0, vram_data.nibbles[stage_job.px[1:0]]};
            color     = {stage_job.palette, pix_value[3:0]};
        end
        // First opaque pixel per column wins, lower OAM index comes first
        write_en = stage_valid && (pix_value != 8'h00) &&
                   !opaque_mem[back_sel][stage_job.column];
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            back_sel      <= 1'b0;
            opaque_mem[0] <= '0;
            opaque_mem[1] <= '0;
            pixel         <= '0;
        end else begin
            if (write_en) begin
                opaque_mem[back_sel][stage_job.column] <= 1'b1;
            end
            if (line_start) begin
                opaque_mem[!back_sel] <= '0;            // Old front becomes empty back
                back_sel              <= !back_sel;
            end
            if (hcount < 8'(LINE_WIDTH)) begin
                pixel <= {opaque_mem[!back_sel][hcount], data_mem[!back_sel][hcount]};
            end else begin
                pixel <= '0;                             // Past the visible line
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_en) begin
            data_mem[back_sel][stage_job.column] <= {stage_job.prio, color};
        end
    end

    // Off-screen columns must already be dropped by the OAM scan
    write_in_line: assert property (
        @(posedge clock) disable iff (reset)
        stage_valid |-> (stage_job.column < 8'(LINE_WIDTH))
    );

endmodule

// ==== obj_renderer_top.sv ====
`timescale 1ns/1ps

module obj_renderer_top #(
    parameter int NUM_OBJECTS = 128,
    parameter int LINE_WIDTH  = 240
) (
    input  logic                clock,
    input  logic                reset,
    output logic [8:0]          oam_addr,
    input  logic [31:0]         oam_data,
    output logic [14:0]         vram_addr,
    input  logic [15:0]         vram_data,
    input  logic                reg_write,
    input  logic [15:0]         reg_wdata,
    input  logic                line_start,
    input  logic [7:0]          line,
    input  logic [7:0]          hcount,
    output obj_pkg::obj_pixel_t pixel,
    output logic                line_done
);
    import obj_pkg::*;

    obj_config_t cfg;
    pixel_job_t  job, stage_job;
    logic        job_valid, stage_valid;

    obj_control_regs u_regs (
        .clock, .reset, .reg_write, .reg_wdata, .line_start, .cfg
    );

    obj_attr_fetch #(.NUM_OBJECTS(NUM_OBJECTS), .LINE_WIDTH(LINE_WIDTH)) u_fetch (
        .clock, .reset, .line_start, .line, .cfg,
        .oam_addr, .oam_data, .job, .job_valid, .line_done
    );

    obj_tile_address u_addr (
        .clock, .reset, .job, .job_valid, .cfg,
        .vram_addr, .stage_job, .stage_valid
    );

    obj_line_buffer #(.LINE_WIDTH(LINE_WIDTH)) u_lbuf (
        .clock, .reset, .line_start, .stage_job, .stage_valid,
        .vram_data, .hcount, .pixel
    );

endmodule

// ==== tb_obj_checks.svh ====
`ifndef TB_OBJ_CHECKS_SVH
`define TB_OBJ_CHECKS_SVH

////////////////////////////////////////////////////////////////////////////
// Error handling, compare tasks and bounded waits
////////////////////////////////////////////////////////////////////////////

task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_pixel(input int column, input obj_pkg::obj_pixel_t actual,
                           input obj_pkg::obj_pixel_t want);
    logic mismatch;
    // Priority and colour of a transparent entry are left over from older lines
    if (want.opaque) begin
        mismatch = (actual !== want);
    end else begin
        mismatch = (actual.opaque !== 1'b0);
    end
    if (mismatch) begin
        stop_on_error($sformatf("FAIL t=%0t pixel[%0d] got %h expected %h",
                                $time, column, actual, want));
    end
endtask

task automatic check_pulse(input string name, input logic actual, input logic want);
    if (actual !== want) begin
        stop_on_error($sformatf("FAIL t=%0t %s got %b expected %b",
                                $time, name, actual, want));
    end
endtask

// Returns on the falling edge where line_done is seen high
task automatic wait_line_done(input int limit);
    int cycles;
    cycles = 0;
    while (line_done !== 1'b1) begin
        if (cycles >= limit) begin
            stop_on_error($sformatf("The scan did not finish: no line_done within %0d cycles",
                                    limit));
        end else begin
            @(negedge clock);
            cycles++;
        end
    end
endtask

`endif

// ==== tb_obj_renderer.sv ====
`timescale 1ns/1ps

module tb_obj_renderer;
    import obj_pkg::*;

    localparam int NUM_OBJECTS = 128;
    localparam int LINE_WIDTH  = 240;
    localparam int SCAN_LIMIT  = 20000;

    logic        clock;
    logic        reset;
    logic [8:0]  oam_addr;
    logic [31:0] oam_data = '0;
    logic [14:0] vram_addr;
    logic [15:0] vram_data = '0;
    logic        reg_write;
    logic [15:0] reg_wdata;
    logic        line_start;
    logic [7:0]  line;
    logic [7:0]  hcount;
    obj_pixel_t  pixel;
    logic        line_done;

    logic [31:0] oam  [256];
    logic [15:0] vram [32768];
    obj_pixel_t  expected [LINE_WIDTH];

    // Sprite size in pixels by shape * 4 + size
    int size_w [12] = '{8, 16, 32, 64, 16, 32, 32, 64, 8, 8, 16, 32};
    int size_h [12] = '{8, 16, 32, 64, 8, 8, 16, 32, 16, 32, 32, 64};

    obj_renderer_top #(.NUM_OBJECTS(NUM_OBJECTS), .LINE_WIDTH(LINE_WIDTH)) UUT (
        .clock, .reset, .oam_addr, .oam_data, .vram_addr, .vram_data,
        .reg_write, .reg_wdata, .line_start, .line, .hcount, .pixel, .line_done
    );

    `include "tb_obj_checks.svh"

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        oam_data  <= oam[oam_addr[7:0]];   // One cycle read latency
        vram_data <= vram[vram_addr];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory contents
    ////////////////////////////////////////////////////////////////////////////

    task automatic fill_vram(input int zero_pct);
        logic [15:0] word;
        for (int a = 0; a < 32768; a++) begin
            for (int n = 0; n < 4; n++) begin
                word[n * 4 +: 4] = ($urandom % 100 < zero_pct) ? 4'h0 : 4'($urandom % 15 + 1);
            end
            vram[a] = word;
        end
    endtask

    task automatic fill_oam(input logic [7:0] target, input int x_span, input int odd_pct);
        logic [31:0] word0;
        logic [1:0]  shape, size;
        for (int i = 0; i < NUM_OBJECTS; i++) begin
            word0 = $urandom;                  // Flips, depth, mosaic and spare bits
            shape = 2'($urandom % 3);
            size  = 2'($urandom % 4);
            word0[7:0]   = ($urandom % 4 != 0) ?
                           target - 8'($urandom % size_h[shape * 4 + size]) : 8'($urandom);
            word0[11:8]  = {1'b0, 1'($urandom), 2'b00};    // Mode 0 or 1, enabled, regular
            word0[15:14] = shape;
            word0[24:16] = 9'($urandom % x_span);
            word0[31:30] = size;
            if ($urandom % 100 < odd_pct) begin
                case ($urandom % 6)
                    0: word0[8] = 1'b1;                                 // Affine
                    1: word0[11] = 1'b1;                                // Window or prohibited
                    2: word0[15:14] = 2'd3;
                    3: word0[24:16] = 9'd448 + 9'($urandom % 64);      // Wraps onto column 0
                    4: word0[24:16] = 9'd240 + 9'($urandom % 208);
                    default: word0[9] = 1'b1;
                endcase
            end
            oam[2 * i]     = word0;
            oam[2 * i + 1] = $urandom;         // Name, priority, palette
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference line
    ////////////////////////////////////////////////////////////////////////////

    function automatic void model_line(input logic [7:0] target, input bit en, input bit map1d);
        logic [31:0] a0;
        logic [15:0] a2, word;
        logic [7:0]  row, value;
        int          w, h, col, px, py, tile, byte_addr, depth;
        for (int c = 0; c < LINE_WIDTH; c++) begin
            expected[c] = '0;
        end
        for (int i = 0; i < NUM_OBJECTS; i++) begin
            a0 = oam[2 * i];
            a2 = oam[2 * i + 1][15:0];
            // Disable, affine, mode bit 1 and the unused shape all hide the object
            if (!en || a0[9] || a0[8] || a0[11] || a0[15:14] == 2'd3) begin
                continue;
            end
            w     = size_w[int'(a0[15:14]) * 4 + int'(a0[31:30])];
            h     = size_h[int'(a0[15:14]) * 4 + int'(a0[31:30])];
            row   = target - a0[7:0];
            depth = a0[13] ? 2 : 1;
            if (int'(row) >= h) begin
                continue;
            end
            for (int c = 0; c < w; c++) begin
                col = (int'(a0[24:16]) + c) % 512;
                if (col >= LINE_WIDTH) begin
                    continue;
                end
                px = a0[28] ? w - 1 - c : c;
                py = a0[29] ? h - 1 - int'(row) : int'(row);
                if (map1d) begin
                    tile = ((py / 8) * (w / 8) + px / 8) * depth;
                end else begin
                    tile = (py / 8) * 32 + (px / 8) * depth;
                end
                byte_addr = (int'(a2[9:0]) + tile) * 32 + (py % 8) * 4 * depth +
                            (px % 8) * depth / 2;
                word = vram[(byte_addr / 2) % 32768];
                if (depth == 2) begin
                    value = 8'(word >> (8 * (px % 2)));
                end else begin
                    value = {4'h0, 4'(word >> (4 * (px % 4)))};
                end
                if (value != 8'h00 && !expected[col].opaque) begin
                    expected[col].opaque = 1'b1;
                    expected[col].prio   = a2[11:10];
                    expected[col].color  = (depth == 2) ? value : {a2[15:12], value[3:0]};
                end
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic write_control(input bit en, input bit map1d);
        logic [15:0] value;
        value     = 16'($urandom);   // Other control bits are ignored by the DUT
        value[12] = en;
        value[6]  = map1d;
        @(negedge clock);
        reg_write = 1'b1;
        reg_wdata = value;
        @(negedge clock);
        reg_write = 1'b0;
    endtask

    task automatic drive_line_start(input logic [7:0] target);
        @(negedge clock);
        line_start = 1'b1;
        line       = target;
        @(negedge clock);
        line_start = 1'b0;
    endtask

    // Scan one line, swap it to the front and compare every column
    task automatic render_and_check(input logic [7:0] target, input bit en, input bit map1d,
                                    input bit write_mid_scan);
        model_line(target, en, map1d);
        drive_line_start(target);
        if (write_mid_scan) begin
            repeat (8) @(negedge clock);
            write_control(!en, !map1d);
        end
        wait_line_done(SCAN_LIMIT);
        @(negedge clock);
        check_pulse("line_done", line_done, 1'b0);
        drive_line_start(target + 8'd1);
        hcount = 8'd0;
        for (int c = 0; c < LINE_WIDTH; c++) begin
            @(negedge clock);
            check_pixel(c, pixel, expected[c]);
            hcount = 8'(c + 1);
        end
    endtask

    task automatic random_lines(input int count, input int x_span, input int odd_pct,
                                input bit both_maps);
        logic [7:0] target;
        bit         map1d;
        for (int n = 0; n < count; n++) begin
            target = 8'($urandom);
            map1d  = 1'($urandom);
            fill_oam(target, x_span, odd_pct);
            write_control(1'b1, map1d);
            render_and_check(target, 1'b1, map1d, 1'b0);
            if (both_maps) begin
                write_control(1'b1, !map1d);
                render_and_check(target, 1'b1, !map1d, 1'b0);
            end
        end
    endtask

    initial begin
        logic [7:0] target;
        void'($urandom(32'h3898e16c));
        reset      = 1'b1;
        reg_write  = 1'b0;
        reg_wdata  = '0;
        line_start = 1'b0;
        line       = '0;
        hcount     = '0;
        repeat (4) @(negedge clock);
        reset = 1'b0;

        // Quiet after reset, first line with the reset configuration
        for (int i = 0; i < 40; i++) begin
            @(negedge clock);
            check_pulse("line_done", line_done, 1'b0);
        end
        fill_vram(40);
        target = 8'($urandom);
        fill_oam(target, LINE_WIDTH, 0);
        render_and_check(target, 1'b0, 1'b0, 1'b0);

        // Objects off by register, then a write during the scan, then by attribute
        write_control(1'b0, 1'b1);
        render_and_check(target, 1'b0, 1'b1, 1'b0);
        write_control(1'b1, 1'b1);
        render_and_check(target, 1'b1, 1'b1, 1'b1);
        render_and_check(target, 1'b0, 1'b0, 1'b0);
        write_control(1'b1, 1'b1);
        for (int i = 0; i < NUM_OBJECTS; i++) begin
            oam[2 * i][9] = 1'b1;
        end
        render_and_check(target, 1'b1, 1'b1, 1'b0);

        random_lines(20, LINE_WIDTH, 5, 1'b0);   // Mixed depths, sizes and flips
        random_lines(4, LINE_WIDTH, 0, 1'b1);    // Same OAM in both tile mappings
        fill_vram(60);
        random_lines(4, 16, 0, 1'b0);            // Dense overlap, many clear pixels
        fill_vram(40);
        random_lines(6, LINE_WIDTH, 70, 1'b0);   // Hidden and off-screen objects

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
obj_pkg.sv
obj_control_regs.sv
obj_attr_fetch.sv
obj_tile_address.sv
obj_line_buffer.sv
obj_renderer_top.sv
tb_obj_renderer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_obj_renderer
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FLIST)) tb_obj_checks.svh

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS"

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "Simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
